// File: common/oflow_dims_pkg.sv
// --------------------------------------------------
// sizes and widths of the history buffer
// frames, slots, boxes and offsets in one place
// imported by the rtl and by the testbench
// --------------------------------------------------
package oflow_dims_pkg;

	// --------------------------------------------------
	// frame numbering and history depth
	// --------------------------------------------------
	localparam int TOTAL_FRAME_NUM_WIDTH = 8;         // serial number, wraps at 256
	localparam int MAX_HISTORY_FRAMES = 4;            // deepest n supported
	localparam int NUM_OF_HISTORY_FRAMES_WIDTH = 3;   // holds n and the step, 0..4

	// one slot per history frame plus the one being written
	localparam int NUM_OF_SLOTS = MAX_HISTORY_FRAMES + 1;
	localparam int SLOT_WIDTH = 3;                    // slot index 0..4

	// --------------------------------------------------
	// boxes within a frame
	// --------------------------------------------------
	localparam int MAX_BBOX_IN_FRAME = 16;
	localparam int NUM_OF_BBOX_IN_FRAME_WIDTH = 5;    // count 0..16, one bit over offset
	localparam int OFFSET_WIDTH = 4;                  // box index 0..15 inside a slot

	// packed box, x in the top byte then y, w, h
	localparam int BBOX_WIDTH = 32;

endpackage

// File: common/oflow_ctrl_pkg.sv
// --------------------------------------------------
// controller definitions of the history buffer
// state encoding and reset values of the
// registered control outputs
// --------------------------------------------------
package oflow_ctrl_pkg;

	// --------------------------------------------------
	// controller states
	// --------------------------------------------------
	typedef enum logic [2:0] {
		IDLE       = 3'd0,  // waits for start_write or start_read
		WRITE      = 3'd1,  // takes one box per valid beat
		READ_SETUP = 3'd2,  // end pointer of the new step settles
		READ_LINE  = 3'd3,  // one line per ready cycle
		READ_DRAIN = 3'd4,  // last line still in flight
		DONE       = 3'd5   // one cycle, done pulse of the phase
	} buf_state_t;

	// --------------------------------------------------
	// reset values
	// --------------------------------------------------
	localparam buf_state_t STATE_RST = IDLE;
	localparam logic RD_PHASE_RST = 1'b0;       // last phase was a write
	localparam logic LINE_VALID_RST = 1'b0;
	localparam logic BBOX_1_VALID_RST = 1'b0;

endpackage

// File: mem_buffer/oflow_mem_buffer_fsm.sv
`timescale 1ns/1ps
// --------------------------------------------------
// controller of the history buffer
// sequences a frame write, or a backward walk over
// the history slots issuing two-box lines while the
// consumer is ready, and raises the done pulses
// --------------------------------------------------
module oflow_mem_buffer_fsm
	import oflow_dims_pkg::*;
	import oflow_ctrl_pkg::*;
(
	input  logic                                   clk,
	input  logic                                   rst,
	input  logic                                   start_write,
	input  logic                                   start_read,
	input  logic                                   bbox_in_valid,
	input  logic                                   similarity_metric_flag_ready_to_read_new_line,
	input  logic [NUM_OF_BBOX_IN_FRAME_WIDTH-1:0]  num_of_bbox_in_frame,
	input  logic [NUM_OF_HISTORY_FRAMES_WIDTH-1:0] num_of_history_frames,
	input  logic [OFFSET_WIDTH-1:0]                offset,
	input  logic [NUM_OF_HISTORY_FRAMES_WIDTH-1:0] hist_step,
	input  logic [NUM_OF_BBOX_IN_FRAME_WIDTH-1:0]  end_ptr,
	output logic                                   we,
	output logic                                   ep_we,
	output logic                                   rd_en,
	output logic                                   off_clr,
	output logic                                   off_inc,
	output logic                                   hist_clr,
	output logic                                   hist_inc,
	output logic                                   slot_inc,
	output logic                                   done_write,
	output logic                                   done_read,
	output logic                                   line_valid,
	output logic                                   bbox_1_valid
);

	buf_state_t state;
	buf_state_t next_state;
	logic rd_phase;     // 1 while the running phase is a read
	logic rdy;
	logic wr_last;      // this beat fills the frame
	logic rd_last;      // this line reaches the end pointer
	logic last_step;    // walk is on the oldest history frame
	logic [NUM_OF_BBOX_IN_FRAME_WIDTH-1:0] off_ext;

	assign rdy = similarity_metric_flag_ready_to_read_new_line;
	assign off_ext = NUM_OF_BBOX_IN_FRAME_WIDTH'(offset);
	assign wr_last = (off_ext + NUM_OF_BBOX_IN_FRAME_WIDTH'(1)) == num_of_bbox_in_frame;
	assign rd_last = (off_ext + NUM_OF_BBOX_IN_FRAME_WIDTH'(2)) >= end_ptr;
	assign last_step = (hist_step == num_of_history_frames);

	// --------------------------------------------------
	// next state and strobes
	// --------------------------------------------------
	always_comb begin
		next_state = state;
		we = 1'b0;
		ep_we = 1'b0;
		rd_en = 1'b0;
		off_clr = 1'b0;
		off_inc = 1'b0;
		hist_clr = 1'b0;
		hist_inc = 1'b0;
		slot_inc = 1'b0;
		done_write = 1'b0;
		done_read = 1'b0;
		case (state)
			IDLE: begin
				if (start_write) begin
					off_clr = 1'b1;
					if (num_of_bbox_in_frame == '0) begin // empty frame, close at once
						ep_we = 1'b1;
						slot_inc = 1'b1;
						next_state = DONE;
					end else begin
						next_state = WRITE;
					end
				end else if (start_read) begin
					off_clr = 1'b1;
					hist_inc = 1'b1; // step 0 -> 1, newest history frame
					next_state = READ_SETUP;
				end
			end
			WRITE: begin
				if (bbox_in_valid) begin
					we = 1'b1;
					off_inc = 1'b1;
					if (wr_last) begin
						ep_we = 1'b1;    // store the count for this slot
						slot_inc = 1'b1;
						next_state = DONE;
					end
				end
			end
			READ_SETUP: begin
				if (end_ptr != '0) begin
					next_state = READ_LINE;
				end else if (last_step) begin // empty slot, nothing left
					next_state = READ_DRAIN;
				end else begin
					hist_inc = 1'b1; // skip the empty slot
				end
			end
			READ_LINE: begin
				if (rdy) begin
					rd_en = 1'b1;
					off_inc = 1'b1;
					if (rd_last) begin
						off_clr = 1'b1; // wins over off_inc
						if (last_step) begin
							next_state = READ_DRAIN;
						end else begin
							hist_inc = 1'b1;
							next_state = READ_SETUP;
						end
					end
				end
			end
			READ_DRAIN: next_state = DONE; // line_valid of the last line
			DONE: begin
				done_write = ~rd_phase;
				done_read = rd_phase;
				hist_clr = rd_phase; // step back to 0 for the next write
				next_state = IDLE;
			end
			default: next_state = IDLE;
		endcase
	end

	// --------------------------------------------------
	// state and line flags
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			state <= STATE_RST;
			rd_phase <= RD_PHASE_RST;
			line_valid <= LINE_VALID_RST;
			bbox_1_valid <= BBOX_1_VALID_RST;
		end else begin
			state <= next_state;
			line_valid <= rd_en; // one cycle after issue
			if (rd_en)
				bbox_1_valid <= (off_ext + NUM_OF_BBOX_IN_FRAME_WIDTH'(1)) < end_ptr;
			if (state == IDLE && start_write)
				rd_phase <= 1'b0;
			else if (state == IDLE && start_read)
				rd_phase <= 1'b1;
		end
	end

endmodule

// File: mem_buffer/oflow_offset_counter.sv
`timescale 1ns/1ps
// --------------------------------------------------
// box offset, history step and write slot counters
// offset steps by one on writes and by two on reads
// slots wrap at n+1, read slot trails the write slot
// --------------------------------------------------
module oflow_offset_counter
	import oflow_dims_pkg::*;
(
	input  logic                                   clk,
	input  logic                                   rst,
	input  logic [NUM_OF_HISTORY_FRAMES_WIDTH-1:0] num_of_history_frames,
	input  logic                                   off_clr,
	input  logic                                   off_inc,
	input  logic                                   hist_clr,
	input  logic                                   hist_inc,
	input  logic                                   slot_inc,
	output logic [OFFSET_WIDTH-1:0]                offset,
	output logic [NUM_OF_HISTORY_FRAMES_WIDTH-1:0] hist_step,
	output logic [SLOT_WIDTH-1:0]                  wr_slot,
	output logic [SLOT_WIDTH-1:0]                  rd_slot
);

	logic [OFFSET_WIDTH-1:0] off_step;
	logic [SLOT_WIDTH-1:0] last_slot; // n, highest slot in use
	logic [SLOT_WIDTH-1:0] step_s;

	// step is 0 only outside a read, so a write
	assign off_step = (hist_step == '0) ? OFFSET_WIDTH'(1) : OFFSET_WIDTH'(2);
	assign last_slot = SLOT_WIDTH'(num_of_history_frames);
	assign step_s = SLOT_WIDTH'(hist_step);

	// --------------------------------------------------
	// counters
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (rst || off_clr)
			offset <= '0;
		else if (off_inc)
			offset <= offset + off_step;
	end

	always_ff @(posedge clk) begin
		if (rst || hist_clr)
			hist_step <= '0;
		else if (hist_inc)
			hist_step <= hist_step + NUM_OF_HISTORY_FRAMES_WIDTH'(1);
	end

	always_ff @(posedge clk) begin
		if (rst)
			wr_slot <= '0;
		else if (slot_inc)
			wr_slot <= (wr_slot == last_slot) ? '0 : wr_slot + SLOT_WIDTH'(1);
	end

	// read slot, wr_slot - step modulo n+1
	always_comb begin
		if (wr_slot >= step_s)
			rd_slot = wr_slot - step_s;
		else
			rd_slot = wr_slot + last_slot + SLOT_WIDTH'(1) - step_s; // wrap back
	end

endmodule

// File: mem_buffer/oflow_end_pointer_table.sv
`timescale 1ns/1ps
// --------------------------------------------------
// end pointer per slot, box count of stored frame
// written once when a frame write closes, read
// combinationally for the slot being replayed
// --------------------------------------------------
module oflow_end_pointer_table
	import oflow_dims_pkg::*;
(
	input  logic                                  clk,
	input  logic                                  rst,
	input  logic                                  ep_we,
	input  logic [SLOT_WIDTH-1:0]                 wr_slot,
	input  logic [NUM_OF_BBOX_IN_FRAME_WIDTH-1:0] num_of_bbox_in_frame,
	input  logic [SLOT_WIDTH-1:0]                 rd_slot,
	output logic [NUM_OF_BBOX_IN_FRAME_WIDTH-1:0] end_ptr
);

	// --------------------------------------------------
	// table
	// --------------------------------------------------
	logic [NUM_OF_BBOX_IN_FRAME_WIDTH-1:0] end_pointers [NUM_OF_SLOTS];

	// cleared at reset, so unwritten slots replay nothing
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < NUM_OF_SLOTS; i++)
				end_pointers[i] <= '0;
		end else if (ep_we) begin
			end_pointers[wr_slot] <= num_of_bbox_in_frame; // slot being closed
		end
	end

	assign end_ptr = end_pointers[rd_slot]; // limits the read walk

endmodule

// File: mem_buffer/oflow_bbox_mem.sv
`timescale 1ns/1ps
// --------------------------------------------------
// box storage, slot by offset
// one write port, two registered read ports at
// offset and offset+1 for a two-box line
// --------------------------------------------------
module oflow_bbox_mem
	import oflow_dims_pkg::*;
(
	input  logic                    clk,
	input  logic                    we,
	input  logic [SLOT_WIDTH-1:0]   wr_slot,
	input  logic [OFFSET_WIDTH-1:0] offset,
	input  logic [BBOX_WIDTH-1:0]   bbox_in,
	input  logic                    rd_en,
	input  logic [SLOT_WIDTH-1:0]   rd_slot,
	output logic [BBOX_WIDTH-1:0]   bbox_0,
	output logic [BBOX_WIDTH-1:0]   bbox_1,
	output logic [OFFSET_WIDTH-1:0] offset_0,
	output logic [OFFSET_WIDTH-1:0] offset_1
);

	logic [BBOX_WIDTH-1:0] mem [NUM_OF_SLOTS][MAX_BBOX_IN_FRAME];
	logic [OFFSET_WIDTH-1:0] offset_nxt;

	// read offsets are even, so +1 never wraps
	assign offset_nxt = offset + OFFSET_WIDTH'(1);

	// --------------------------------------------------
	// write port
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (we)
			mem[wr_slot][offset] <= bbox_in;
	end

	// --------------------------------------------------
	// read ports, data and offsets stay together
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (rd_en) begin
			bbox_0 <= mem[rd_slot][offset];
			bbox_1 <= mem[rd_slot][offset_nxt]; // don't care past end, flagged by fsm
			offset_0 <= offset;
			offset_1 <= offset_nxt;
		end
	end

endmodule

// File: hdl/oflow_mem_buffer_top.sv
`timescale 1ns/1ps
// --------------------------------------------------
// history buffer of the tracker
// stores each frame's boxes in a circular slot set
// and replays the history to the similarity stage
// two boxes per line under its ready flag
// --------------------------------------------------
module oflow_mem_buffer_top
	import oflow_dims_pkg::*;
(
	input  logic                                   clk,
	input  logic                                   rst,
	input  logic [TOTAL_FRAME_NUM_WIDTH-1:0]       frame_num,
	input  logic [NUM_OF_HISTORY_FRAMES_WIDTH-1:0] num_of_history_frames, // n, 1..4
	input  logic [NUM_OF_BBOX_IN_FRAME_WIDTH-1:0]  num_of_bbox_in_frame,
	input  logic                                   start_write,
	input  logic [BBOX_WIDTH-1:0]                  bbox_in,
	input  logic                                   bbox_in_valid,
	input  logic                                   start_read,
	input  logic                                   similarity_metric_flag_ready_to_read_new_line,
	output logic                                   done_write,
	output logic                                   done_read,
	output logic                                   line_valid,
	output logic [BBOX_WIDTH-1:0]                  bbox_0,
	output logic [BBOX_WIDTH-1:0]                  bbox_1,
	output logic                                   bbox_1_valid,
	output logic [TOTAL_FRAME_NUM_WIDTH-1:0]       frame_to_read,
	output logic [OFFSET_WIDTH-1:0]                offset_0,
	output logic [OFFSET_WIDTH-1:0]                offset_1,
	output logic                                   we,
	output logic [NUM_OF_HISTORY_FRAMES_WIDTH-1:0] counter_of_history_frame_to_interface
);

	// --------------------------------------------------
	// internal nets
	// --------------------------------------------------
	logic ep_we;
	logic rd_en;
	logic off_clr;
	logic off_inc;
	logic hist_clr;
	logic hist_inc;
	logic slot_inc;
	logic [OFFSET_WIDTH-1:0] offset;
	logic [NUM_OF_HISTORY_FRAMES_WIDTH-1:0] hist_step;
	logic [SLOT_WIDTH-1:0] wr_slot;
	logic [SLOT_WIDTH-1:0] rd_slot;
	logic [NUM_OF_BBOX_IN_FRAME_WIDTH-1:0] end_ptr;

	// --------------------------------------------------
	// blocks
	// --------------------------------------------------
	oflow_mem_buffer_fsm u_fsm (
		.clk(clk),
		.rst(rst),
		.start_write(start_write),
		.start_read(start_read),
		.bbox_in_valid(bbox_in_valid),
		.similarity_metric_flag_ready_to_read_new_line(
			similarity_metric_flag_ready_to_read_new_line),
		.num_of_bbox_in_frame(num_of_bbox_in_frame),
		.num_of_history_frames(num_of_history_frames),
		.offset(offset),
		.hist_step(hist_step),
		.end_ptr(end_ptr),
		.we(we),
		.ep_we(ep_we),
		.rd_en(rd_en),
		.off_clr(off_clr),
		.off_inc(off_inc),
		.hist_clr(hist_clr),
		.hist_inc(hist_inc),
		.slot_inc(slot_inc),
		.done_write(done_write),
		.done_read(done_read),
		.line_valid(line_valid),
		.bbox_1_valid(bbox_1_valid)
	);

	oflow_offset_counter u_counter (
		.clk(clk),
		.rst(rst),
		.num_of_history_frames(num_of_history_frames),
		.off_clr(off_clr),
		.off_inc(off_inc),
		.hist_clr(hist_clr),
		.hist_inc(hist_inc),
		.slot_inc(slot_inc),
		.offset(offset),
		.hist_step(hist_step),
		.wr_slot(wr_slot),
		.rd_slot(rd_slot)
	);

	oflow_end_pointer_table u_end_ptr (
		.clk(clk),
		.rst(rst),
		.ep_we(ep_we),
		.wr_slot(wr_slot),
		.num_of_bbox_in_frame(num_of_bbox_in_frame),
		.rd_slot(rd_slot),
		.end_ptr(end_ptr)
	);

	oflow_bbox_mem u_mem (
		.clk(clk),
		.we(we),
		.wr_slot(wr_slot),
		.offset(offset),
		.bbox_in(bbox_in),
		.rd_en(rd_en),
		.rd_slot(rd_slot),
		.bbox_0(bbox_0),
		.bbox_1(bbox_1),
		.offset_0(offset_0),
		.offset_1(offset_1)
	);

	// line tags, captured with the issue like the box data
	always_ff @(posedge clk) begin
		if (rd_en) begin
			frame_to_read <= frame_num - TOTAL_FRAME_NUM_WIDTH'(hist_step); // mod 256
			counter_of_history_frame_to_interface <= hist_step;
		end
	end

endmodule

// File: verification/oflow_mem_buffer_tb.sv
`timescale 1ns/1ps
// --------------------------------------------------
// testbench of the history buffer
// applies a table of frame writes and history reads,
// predicts every line from a slot model and checks
// lines, done pulses and write strobes
// --------------------------------------------------
module oflow_mem_buffer_tb
	import oflow_dims_pkg::*;
();

	localparam int NUM_ROWS = 20;
	localparam int MAX_LINES = MAX_HISTORY_FRAMES * MAX_BBOX_IN_FRAME / 2;
	localparam int WATCHDOG_CYCLES = NUM_ROWS * MAX_LINES * 20;
	localparam int OP_LIMIT = MAX_LINES * 10; // cycles to wait for one done pulse

	typedef struct packed {
		bit rst_before;  // reset and set n before this row
		bit is_read;
		bit ign;         // pulse the other start while busy
		int frame;
		int cnt;
		int n;
		int density;     // percent of cycles with ready high
	} row_t;

	typedef struct packed {
		logic [BBOX_WIDTH-1:0] b0;
		logic [BBOX_WIDTH-1:0] b1;
		logic v1;
		logic [TOTAL_FRAME_NUM_WIDTH-1:0] frame;
		logic [NUM_OF_HISTORY_FRAMES_WIDTH-1:0] step;
		logic [OFFSET_WIDTH-1:0] off;
		logic [OFFSET_WIDTH-1:0] off1;
	} line_t;

	// --------------------------------------------------
	// test table
	// --------------------------------------------------
	row_t rows [NUM_ROWS] = '{
		'{1'b1, 1'b1, 1'b0, 0, 0, 2, 100},   // read with empty history
		'{1'b0, 1'b0, 1'b0, 0, 4, 2, 100},
		'{1'b0, 1'b0, 1'b0, 1, 5, 2, 100},   // odd count
		'{1'b0, 1'b0, 1'b1, 2, 6, 2, 100},   // start_read while writing
		'{1'b0, 1'b1, 1'b0, 3, 0, 2, 100},
		'{1'b0, 1'b1, 1'b1, 3, 0, 2, 40},    // stalls and start_write while reading
		'{1'b1, 1'b0, 1'b0, 10, 3, 2, 100},  // wraparound run
		'{1'b0, 1'b0, 1'b0, 11, 7, 2, 100},
		'{1'b0, 1'b0, 1'b0, 12, 2, 2, 100},
		'{1'b0, 1'b0, 1'b0, 13, 8, 2, 100},
		'{1'b0, 1'b0, 1'b0, 14, 1, 2, 100},
		'{1'b0, 1'b0, 1'b0, 15, 4, 2, 100},
		'{1'b0, 1'b1, 1'b0, 16, 0, 2, 100},
		'{1'b0, 1'b1, 1'b0, 16, 0, 2, 30},
		'{1'b1, 1'b0, 1'b0, 254, 16, 4, 100}, // full frame with n=4
		'{1'b0, 1'b0, 1'b0, 255, 0, 4, 100},  // empty frame
		'{1'b0, 1'b0, 1'b0, 0, 9, 4, 100},
		'{1'b0, 1'b1, 1'b0, 1, 0, 4, 60},     // frame_to_read wraps below 0
		'{1'b1, 1'b0, 1'b0, 50, 3, 1, 100},
		'{1'b0, 1'b1, 1'b1, 51, 0, 1, 50}
	};

	logic clk = 1'b0;
	logic rst;
	logic [TOTAL_FRAME_NUM_WIDTH-1:0] frame_num;
	logic [NUM_OF_HISTORY_FRAMES_WIDTH-1:0] num_of_history_frames;
	logic [NUM_OF_BBOX_IN_FRAME_WIDTH-1:0] num_of_bbox_in_frame;
	logic start_write;
	logic [BBOX_WIDTH-1:0] bbox_in;
	logic bbox_in_valid;
	logic start_read;
	logic ready;
	logic done_write;
	logic done_read;
	logic line_valid;
	logic [BBOX_WIDTH-1:0] bbox_0;
	logic [BBOX_WIDTH-1:0] bbox_1;
	logic bbox_1_valid;
	logic [TOTAL_FRAME_NUM_WIDTH-1:0] frame_to_read;
	logic [OFFSET_WIDTH-1:0] offset_0;
	logic [OFFSET_WIDTH-1:0] offset_1;
	logic we;
	logic [NUM_OF_HISTORY_FRAMES_WIDTH-1:0] counter_of_history_frame_to_interface;

	// slot model
	logic [BBOX_WIDTH-1:0] m_mem [NUM_OF_SLOTS][MAX_BBOX_IN_FRAME];
	int m_ep [NUM_OF_SLOTS];
	int m_wr_slot;
	int m_n;
	line_t exp_q [$];

	int errors = 0;
	int checks = 0;
	int line_errors = 0;  // owned by the monitor
	int line_checks = 0;
	int dw_cnt = 0;
	int dr_cnt = 0;
	int we_cnt = 0;
	logic prev_rdy = 1'b0;
	line_t want;

	always #4 clk = ~clk; // 8 ns period

	oflow_mem_buffer_top u_oflow_mem_buffer_top (
		.clk(clk),
		.rst(rst),
		.frame_num(frame_num),
		.num_of_history_frames(num_of_history_frames),
		.num_of_bbox_in_frame(num_of_bbox_in_frame),
		.start_write(start_write),
		.bbox_in(bbox_in),
		.bbox_in_valid(bbox_in_valid),
		.start_read(start_read),
		.similarity_metric_flag_ready_to_read_new_line(ready),
		.done_write(done_write),
		.done_read(done_read),
		.line_valid(line_valid),
		.bbox_0(bbox_0),
		.bbox_1(bbox_1),
		.bbox_1_valid(bbox_1_valid),
		.frame_to_read(frame_to_read),
		.offset_0(offset_0),
		.offset_1(offset_1),
		.we(we),
		.counter_of_history_frame_to_interface(counter_of_history_frame_to_interface)
	);

	function automatic logic pick_ready(input int density);
		return int'($urandom_range(99)) < density;
	endfunction

	// lines of one read from the newest history frame back
	task automatic predict_read(input int frame);
		int s;
		int slot;
		int o;
		line_t e;
		for (s = 1; s <= m_n; s++) begin
			slot = (m_wr_slot - s + m_n + 1) % (m_n + 1);
			for (o = 0; o < m_ep[slot]; o += 2) begin
				e.b0 = m_mem[slot][o];
				e.v1 = (o + 1 < m_ep[slot]);
				e.b1 = e.v1 ? m_mem[slot][o + 1] : '0;
				e.frame = TOTAL_FRAME_NUM_WIDTH'(frame - s); // mod 256
				e.step = NUM_OF_HISTORY_FRAMES_WIDTH'(s);
				e.off = OFFSET_WIDTH'(o);
				e.off1 = OFFSET_WIDTH'(o + 1);
				exp_q.push_back(e);
			end
		end
	endtask

	// --------------------------------------------------
	// reset with a new history depth
	// --------------------------------------------------
	task automatic apply_reset(input int n);
		@(posedge clk);
		rst <= 1'b1;
		num_of_history_frames <= NUM_OF_HISTORY_FRAMES_WIDTH'(n);
		repeat (16) @(posedge clk);
		rst <= 1'b0;
		m_n = n;
		m_wr_slot = 0;
		for (int i = 0; i < NUM_OF_SLOTS; i++)
			m_ep[i] = 0;
		@(negedge clk);
		checks++;
		if (done_write || done_read || line_valid || bbox_1_valid || we) begin
			$display("ERR t=%0t: outputs not low after reset", $time);
			errors++;
		end
	endtask

	task automatic run_write(input int idx);
		int sent;
		int cyc;
		int dw0;
		int dr0;
		int we0;
		logic v;
		logic [BBOX_WIDTH-1:0] b;
		dw0 = dw_cnt;
		dr0 = dr_cnt;
		we0 = we_cnt;
		@(posedge clk);
		start_write <= 1'b1;
		frame_num <= TOTAL_FRAME_NUM_WIDTH'(rows[idx].frame);
		num_of_bbox_in_frame <= NUM_OF_BBOX_IN_FRAME_WIDTH'(rows[idx].cnt);
		@(posedge clk);
		start_write <= 1'b0;
		sent = 0;
		cyc = 0;
		while (sent < rows[idx].cnt) begin
			v = ($urandom_range(3) != 0); // about one gap in four
			b = $urandom;
			bbox_in <= b;
			bbox_in_valid <= v;
			start_read <= rows[idx].ign && cyc == 0;
			if (v) begin
				m_mem[m_wr_slot][sent] = b;
				sent++;
			end
			cyc++;
			@(posedge clk);
		end
		bbox_in_valid <= 1'b0;
		start_read <= 1'b0;
		m_ep[m_wr_slot] = rows[idx].cnt;
		m_wr_slot = (m_wr_slot == m_n) ? 0 : m_wr_slot + 1;
		cyc = 0;
		while (dw_cnt == dw0 && cyc < OP_LIMIT) begin
			@(posedge clk);
			cyc++;
		end
		if (dw_cnt == dw0) begin
			$display("test %0d: done_write never arrived", idx);
			errors++;
		end
		repeat (3) @(posedge clk); // a second pulse would show here
		checks += 2;
		if (dw_cnt != dw0 + 1 || dr_cnt != dr0) begin
			$display("ERR t=%0t: %0d done_write and %0d done_read pulses", $time,
				dw_cnt - dw0, dr_cnt - dr0);
			errors++;
		end
		if (we_cnt != we0 + rows[idx].cnt) begin
			$display("ERR t=%0t: %0d we cycles for %0d boxes", $time, we_cnt - we0,
				rows[idx].cnt);
			errors++;
		end
	endtask

	task automatic run_read(input int idx);
		int cyc;
		int dw0;
		int dr0;
		int we0;
		dw0 = dw_cnt;
		dr0 = dr_cnt;
		we0 = we_cnt;
		predict_read(rows[idx].frame);
		@(posedge clk);
		start_read <= 1'b1;
		frame_num <= TOTAL_FRAME_NUM_WIDTH'(rows[idx].frame);
		ready <= pick_ready(rows[idx].density);
		@(posedge clk);
		start_read <= 1'b0;
		cyc = 0;
		while (dr_cnt == dr0 && cyc < OP_LIMIT) begin
			ready <= pick_ready(rows[idx].density);
			start_write <= rows[idx].ign && cyc == 0;
			cyc++;
			@(posedge clk);
		end
		start_write <= 1'b0;
		ready <= 1'b1;
		if (dr_cnt == dr0) begin
			$display("test %0d: done_read never arrived", idx);
			errors++;
		end
		// every line is out by the time done_read is seen
		if (exp_q.size() != 0) begin
			$display("ERR t=%0t: %0d predicted lines missing at done_read", $time,
				exp_q.size());
			errors++;
			exp_q.delete();
		end
		repeat (3) @(posedge clk);
		checks += 3;
		if (dr_cnt != dr0 + 1 || dw_cnt != dw0 || we_cnt != we0) begin
			$display("ERR t=%0t: %0d done_read, %0d done_write, %0d we cycles", $time,
				dr_cnt - dr0, dw_cnt - dw0, we_cnt - we0);
			errors++;
		end
	endtask

	// --------------------------------------------------
	// monitor samples at negedge with outputs settled
	// --------------------------------------------------
	always @(negedge clk) begin
		if (!rst) begin
			if (done_write)
				dw_cnt++;
			if (done_read)
				dr_cnt++;
			if (we)
				we_cnt++;
			if (line_valid) begin
				line_checks++;
				if (!prev_rdy) begin // issued while ready was low
					$display("ERR t=%0t: line_valid without ready", $time);
					line_errors++;
				end
				if (exp_q.size() == 0) begin
					$display("ERR t=%0t: unexpected line_valid", $time);
					line_errors++;
				end else begin
					want = exp_q.pop_front();
					if (bbox_0 !== want.b0 || bbox_1_valid !== want.v1
						|| (want.v1 && bbox_1 !== want.b1) || frame_to_read !== want.frame
						|| counter_of_history_frame_to_interface !== want.step
						|| offset_0 !== want.off || offset_1 !== want.off1) begin
						$display("ERR t=%0t: line frame %0d off %0d want %h %h v1 %0b", $time,
							want.frame, want.off, want.b0, want.b1, want.v1);
						$display("ERR t=%0t: got frame %0d step %0d off %0d %0d %h %h v1 %0b",
							$time, frame_to_read, counter_of_history_frame_to_interface,
							offset_0, offset_1, bbox_0, bbox_1, bbox_1_valid);
						line_errors++;
					end
				end
			end
		end
		prev_rdy = ready;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("watchdog: the run did not finish in time");
		$display("TESTS FAILED");
		$finish;
	end

	initial begin
		int seed;
		int err0;
		seed = $urandom(32'hc4e2_4be0);
		rst <= 1'b1;
		frame_num <= '0;
		num_of_history_frames <= NUM_OF_HISTORY_FRAMES_WIDTH'(rows[0].n);
		num_of_bbox_in_frame <= '0;
		start_write <= 1'b0;
		bbox_in <= '0;
		bbox_in_valid <= 1'b0;
		start_read <= 1'b0;
		ready <= 1'b1;
		for (int i = 0; i < NUM_ROWS; i++) begin
			if (rows[i].rst_before)
				apply_reset(rows[i].n);
			err0 = errors + line_errors;
			if (rows[i].is_read)
				run_read(i);
			else
				run_write(i);
			$display("test %0d %s frame %0d: %s", i, rows[i].is_read ? "read" : "write",
				rows[i].frame, (errors + line_errors == err0) ? "ok" : "mismatch");
		end
		errors += line_errors;
		$display("%0d tests, %0d checks, %0d errors", NUM_ROWS, checks + line_checks, errors);
		if (errors == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

// File: oflow_mem_buffer.f
common/oflow_dims_pkg.sv
common/oflow_ctrl_pkg.sv
mem_buffer/oflow_mem_buffer_fsm.sv
mem_buffer/oflow_offset_counter.sv
mem_buffer/oflow_end_pointer_table.sv
mem_buffer/oflow_bbox_mem.sv
hdl/oflow_mem_buffer_top.sv
verification/oflow_mem_buffer_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the history buffer testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
	--top-module oflow_mem_buffer_tb \
	-f oflow_mem_buffer.f \
	-o oflow_mem_buffer_sim

./obj_dir/oflow_mem_buffer_sim | tee sim.log

if grep -q "TESTS PASSED" sim.log; then
	echo "simulation ok"
else
	echo "simulation reported errors, see sim.log"
	exit 1
fi
